/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_kcpu
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
kcpu_isa_pkg.sv
kcpu_bus_pkg.sv
kcpu_alu.sv
kcpu_pc.sv
kcpu_regs.sv
kcpu_memctrl.sv
kcpu_ctrl.sv
kcpu.sv
tb_kcpu.sv

/* kcpu.sv */
// kcpu top level
// 8-bit accumulator core on a 16-bit address bus with separate data
// in and out and a write strobe. cen gates every state change
`timescale 1ns/10ps

module kcpu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            halt,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] din,
    output logic [kcpu_bus_pkg::DATA_W-1:0] dout,
    output logic [kcpu_bus_pkg::ADDR_W-1:0] addr,
    output logic                            we
);
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] a, b, cc, alu_res;
    logic [2:0]        alu_cc;
    alu_fn_e           alu_fn;
    logic              pc_inc, pc_ld_hi, pc_ld_lo;
    logic              ea_hi, ea_lo, use_ea, wr, st_b, opnd_b;
    logic              up_a, up_b, up_cc;

    kcpu_ctrl u_ctrl (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .halt     ( halt     ),
        .din      ( din      ),
        .pc_inc   ( pc_inc   ),
        .pc_ld_hi ( pc_ld_hi ),
        .pc_ld_lo ( pc_ld_lo ),
        .ea_hi    ( ea_hi    ),
        .ea_lo    ( ea_lo    ),
        .use_ea   ( use_ea   ),
        .wr       ( wr       ),
        .st_b     ( st_b     ),
        .opnd_b   ( opnd_b   ),
        .up_a     ( up_a     ),
        .up_b     ( up_b     ),
        .up_cc    ( up_cc    ),
        .alu_fn   ( alu_fn   )
    );

    kcpu_pc u_pc (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .pc_inc   ( pc_inc   ),
        .pc_ld_hi ( pc_ld_hi ),
        .pc_ld_lo ( pc_ld_lo ),
        .din      ( din      ),
        .pc       ( pc       )
    );

    kcpu_regs u_regs (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .up_a     ( up_a     ),
        .up_b     ( up_b     ),
        .up_cc    ( up_cc    ),
        .alu_res  ( alu_res  ),
        .alu_cc   ( alu_cc   ),
        .din      ( din      ),
        .a        ( a        ),
        .b        ( b        ),
        .cc       ( cc       )
    );

    kcpu_alu u_alu (
        .alu_fn   ( alu_fn   ),
        .opnd_b   ( opnd_b   ),
        .a        ( a        ),
        .b        ( b        ),
        .din      ( din      ),
        .c_in     ( cc[CC_C] ),
        .res      ( alu_res  ),
        .flags    ( alu_cc   )
    );

    kcpu_memctrl u_memctrl (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .ea_hi    ( ea_hi    ),
        .ea_lo    ( ea_lo    ),
        .use_ea   ( use_ea   ),
        .wr       ( wr       ),
        .st_b     ( st_b     ),
        .din      ( din      ),
        .pc       ( pc       ),
        .a        ( a        ),
        .b        ( b        ),
        .addr     ( addr     ),
        .dout     ( dout     ),
        .we       ( we       )
    );

endmodule

/* kcpu_alu.sv */
// kcpu arithmetic and logic unit
// combinational 8-bit ALU with operand select between the data bus
// and B, producing the result and the N, Z, C flags
`timescale 1ns/10ps

module kcpu_alu (
    input  kcpu_isa_pkg::alu_fn_e           alu_fn,
    input  logic                            opnd_b,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] a,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] b,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] din,
    input  logic                            c_in,
    output logic [kcpu_bus_pkg::DATA_W-1:0] res,
    output logic [2:0]                      flags
);
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    logic [DATA_W-1:0] opnd;
    logic [DATA_W:0]   sum;
    logic              c_out;

    // B for ABA, immediate byte otherwise
    assign opnd = opnd_b ? b : din;

    always_comb begin
        sum   = '0;
        c_out = c_in;
        res   = opnd;
        case (alu_fn)
            ADD: begin
                sum   = {1'b0, a} + {1'b0, opnd};
                res   = sum[DATA_W-1:0];
                c_out = sum[DATA_W];
            end
            ADC: begin
                sum   = {1'b0, a} + {1'b0, opnd} + {{DATA_W{1'b0}}, c_in};
                res   = sum[DATA_W-1:0];
                c_out = sum[DATA_W];
            end
            SUB: begin
                // carry out of the subtraction is the borrow
                sum   = {1'b0, a} - {1'b0, opnd};
                res   = sum[DATA_W-1:0];
                c_out = sum[DATA_W];
            end
            AND:     res = a & opnd;
            EOR:     res = a ^ opnd;
            default: res = opnd;
        endcase
    end

    assign flags = {res[DATA_W-1], res == '0, c_out};

endmodule

/* kcpu_bus_pkg.sv */
// kcpu memory bus definitions
// bus widths and the address of the first fetch
package kcpu_bus_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // execution starts here after reset
    localparam logic [ADDR_W-1:0] RESET_VEC = 16'h0000;

endpackage

/* kcpu_ctrl.sv */
// kcpu control unit
// instruction sequencer: decodes the opcode byte on din during FETCH,
// the latched opcode afterwards, and raises the strobes for the
// program counter, register file, ALU and memory controller
`timescale 1ns/10ps

module kcpu_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            halt,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] din,
    output logic                            pc_inc,
    output logic                            pc_ld_hi,
    output logic                            pc_ld_lo,
    output logic                            ea_hi,
    output logic                            ea_lo,
    output logic                            use_ea,
    output logic                            wr,
    output logic                            st_b,
    output logic                            opnd_b,
    output logic                            up_a,
    output logic                            up_b,
    output logic                            up_cc,
    output kcpu_isa_pkg::alu_fn_e           alu_fn
);
    import kcpu_isa_pkg::*;

    state_e  state;
    state_e  state_nx;
    opcode_e op;
    logic    op_ld;

    function automatic alu_fn_e imm_fn(input opcode_e code);
        case (code)
            ADDA:    imm_fn = ADD;
            ADCA:    imm_fn = ADC;
            SUBA:    imm_fn = SUB;
            ANDA:    imm_fn = AND;
            EORA:    imm_fn = EOR;
            default: imm_fn = PASS;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
            op    <= NOP;
        end else if (cen) begin
            state <= state_nx;
            if (op_ld) begin
                op <= opcode_e'(din);
            end
        end
    end

    always_comb begin
        state_nx = state;
        op_ld    = 1'b0;
        pc_inc   = 1'b0;
        pc_ld_hi = 1'b0;
        pc_ld_lo = 1'b0;
        ea_hi    = 1'b0;
        ea_lo    = 1'b0;
        wr       = 1'b0;
        opnd_b   = 1'b0;
        up_a     = 1'b0;
        up_b     = 1'b0;
        up_cc    = 1'b0;
        alu_fn   = PASS;
        case (state)
            FETCH: begin
                // halt only takes effect between instructions
                if (halt) begin
                    state_nx = HALTED;
                end else begin
                    pc_inc = 1'b1;
                    case (din)
                        ABA: begin
                            alu_fn = ADD;
                            opnd_b = 1'b1;
                            up_a   = 1'b1;
                            up_cc  = 1'b1;
                        end
                        LDA, LDB, ADDA, ADCA, SUBA, ANDA, EORA: begin
                            op_ld    = 1'b1;
                            state_nx = OPND;
                        end
                        STA, STB, JMP: begin
                            op_ld    = 1'b1;
                            state_nx = ADRH;
                        end
                        // NOP and unknown bytes
                        default: ;
                    endcase
                end
            end
            OPND: begin
                pc_inc   = 1'b1;
                up_cc    = 1'b1;
                alu_fn   = imm_fn(op);
                up_a     = (op != LDB);
                up_b     = (op == LDB);
                state_nx = FETCH;
            end
            ADRH: begin
                pc_inc   = 1'b1;
                pc_ld_hi = (op == JMP);
                ea_hi    = (op != JMP);
                state_nx = ADRL;
            end
            ADRL: begin
                if (op == JMP) begin
                    // full target load replaces the increment
                    pc_ld_lo = 1'b1;
                    state_nx = FETCH;
                end else begin
                    pc_inc   = 1'b1;
                    ea_lo    = 1'b1;
                    wr       = 1'b1;
                    state_nx = WRITE;
                end
            end
            WRITE: state_nx = FETCH;
            HALTED: begin
                if (!halt) begin
                    state_nx = FETCH;
                end
            end
            default: state_nx = FETCH;
        endcase
    end

    assign use_ea = (state == WRITE);
    assign st_b   = (op == STB);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {FETCH, OPND, ADRH, ADRL, WRITE, HALTED});

    // a write request always leads straight into the WRITE cycle
    a_wr_to_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr && cen |=> state == WRITE);

endmodule

/* kcpu_isa_pkg.sv */
// kcpu instruction set definitions
// opcode encodings, sequencer states, ALU functions and the
// positions of the condition code flags inside CC
package kcpu_isa_pkg;

    // one-byte opcodes, anything else runs as NOP
    typedef enum logic [7:0] {
        NOP  = 8'h12,
        LDA  = 8'h86,
        LDB  = 8'hC6,
        ADDA = 8'h8B,
        ADCA = 8'h89,
        SUBA = 8'h80,
        ANDA = 8'h84,
        EORA = 8'h88,
        ABA  = 8'h3A,
        STA  = 8'hB7,
        STB  = 8'hF7,
        JMP  = 8'h7E
    } opcode_e;

    typedef enum logic [2:0] {
        FETCH,
        OPND,
        ADRH,
        ADRL,
        WRITE,
        HALTED
    } state_e;

    typedef enum logic [2:0] {
        PASS,
        ADD,
        ADC,
        SUB,
        AND,
        EOR
    } alu_fn_e;

    // flag bits in CC, the rest read as zero
    localparam int CC_N = 3;
    localparam int CC_Z = 2;
    localparam int CC_C = 0;

endpackage

/* kcpu_memctrl.sv */
// kcpu memory controller
// drives the address bus from the PC or the latched effective
// address, and the store data and write strobe for STA/STB
`timescale 1ns/10ps

module kcpu_memctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            ea_hi,
    input  logic                            ea_lo,
    input  logic                            use_ea,
    input  logic                            wr,
    input  logic                            st_b,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] din,
    input  logic [kcpu_bus_pkg::ADDR_W-1:0] pc,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] a,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] b,
    output logic [kcpu_bus_pkg::ADDR_W-1:0] addr,
    output logic [kcpu_bus_pkg::DATA_W-1:0] dout,
    output logic                            we
);
    import kcpu_bus_pkg::*;

    logic [ADDR_W-1:0] ea_addr;

    always_ff @(posedge clk) begin
        if (cen && ea_hi) begin
            ea_addr[ADDR_W-1:DATA_W] <= din;
        end
        if (cen && ea_lo) begin
            ea_addr[DATA_W-1:0] <= din;
        end
    end

    // request comes one cycle early, in ADRL
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we <= 1'b0;
        end else if (cen) begin
            we <= wr;
        end
    end

    assign addr = use_ea ? ea_addr : pc;
    assign dout = st_b ? b : a;

    a_we_on_ea: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> use_ea);

    a_dout_stable: assert property (@(posedge clk) disable iff (!rst_n)
        we && $past(we) |-> $stable(dout));

endmodule

/* kcpu_pc.sv */
// kcpu program counter
// counts through the instruction stream and takes a two-byte jump
// target, high byte first into a holding register
`timescale 1ns/10ps

module kcpu_pc (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            pc_inc,
    input  logic                            pc_ld_hi,
    input  logic                            pc_ld_lo,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] din,
    output logic [kcpu_bus_pkg::ADDR_W-1:0] pc
);
    import kcpu_bus_pkg::*;

    logic [DATA_W-1:0] jmp_hi;

    always_ff @(posedge clk) begin
        if (cen && pc_ld_hi) begin
            jmp_hi <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_VEC;
        end else if (cen) begin
            if (pc_ld_lo) begin
                pc <= {jmp_hi, din};
            end else if (pc_inc) begin
                pc <= pc + 1'b1;
            end
        end
    end

    a_no_inc_on_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(pc_inc && pc_ld_lo));

endmodule

/* kcpu_regs.sv */
// kcpu register file
// accumulators A and B plus the CC register. A takes the ALU result,
// B loads straight from the data bus, CC takes the ALU flags
`timescale 1ns/10ps

module kcpu_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            up_a,
    input  logic                            up_b,
    input  logic                            up_cc,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] alu_res,
    input  logic [2:0]                      alu_cc,
    input  logic [kcpu_bus_pkg::DATA_W-1:0] din,
    output logic [kcpu_bus_pkg::DATA_W-1:0] a,
    output logic [kcpu_bus_pkg::DATA_W-1:0] b,
    output logic [kcpu_bus_pkg::DATA_W-1:0] cc
);
    import kcpu_isa_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a  <= '0;
            b  <= '0;
            cc <= '0;
        end else if (cen) begin
            if (up_a) begin
                a <= alu_res;
            end
            if (up_b) begin
                b <= din;
            end
            // alu_cc is ordered {N, Z, C}
            if (up_cc) begin
                cc[CC_N] <= alu_cc[2];
                cc[CC_Z] <= alu_cc[1];
                cc[CC_C] <= alu_cc[0];
            end
        end
    end

endmodule

/* tb_kcpu.sv */
// kcpu testbench
// runs one random program three times (cen high, cen gated, cen gated
// with halt pulses) and checks the writes on the bus against a model
`timescale 1ns/10ps

module tb_kcpu;
    import kcpu_isa_pkg::*;
    import kcpu_bus_pkg::*;

    localparam int N_INSTR   = 60;
    // four cycles per instruction, four for cen duty, margin for halt and tail
    localparam int CYC_LIMIT = (N_INSTR + 1) * 4 * 4 + 600;

    logic              clk;
    logic              rst_n;
    logic              cen;
    logic              halt;
    logic [DATA_W-1:0] din;
    logic [DATA_W-1:0] dout;
    logic [ADDR_W-1:0] addr;
    logic              we;

    logic [7:0]        mem [0:65535];
    logic [7:0]        prog [0:255];
    int                prog_len;
    logic [ADDR_W-1:0] end_addr;
    logic [ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [31:0]       rng_state;
    int                cycles;
    int                val_errors;
    int                other_errors;
    int                writes_seen;

    kcpu kcpu_i (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cen   ( cen   ),
        .halt  ( halt  ),
        .din   ( din   ),
        .dout  ( dout  ),
        .addr  ( addr  ),
        .we    ( we    )
    );

    // memory answers in the same cycle
    assign din = mem[addr];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYC_LIMIT) begin
            $display("timeout, run did not reach the end within %0d cycles", CYC_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int op_len(input logic [7:0] op);
        case (op)
            NOP, ABA:      return 1;
            STA, STB, JMP: return 3;
            default:       return 2;
        endcase
    endfunction

    task automatic gen_program();
        opcode_e     kinds [12];
        opcode_e     ops [N_INSTR];
        int          at [N_INSTR+1];
        int          pos;
        int          span;
        int          pick;
        logic [15:0] tgt;
        kinds = '{NOP, LDA, LDB, ADDA, ADCA, SUBA, ANDA, EORA, ABA, STA, STB, JMP};
        pos = 0;
        for (int i = 0; i < N_INSTR; i++) begin
            ops[i] = kinds[next_rand() % 12];
            at[i]  = pos;
            pos    = pos + op_len(ops[i]);
        end
        at[N_INSTR] = pos;
        end_addr    = RESET_VEC + 16'(pos);
        for (int i = 0; i < N_INSTR; i++) begin
            prog[at[i]] = ops[i];
            case (ops[i])
                NOP, ABA: ;
                STA, STB: begin
                    prog[at[i] + 1] = 8'h80;
                    prog[at[i] + 2] = 8'(next_rand());
                end
                JMP: begin
                    // forward by one to four instructions
                    span = (N_INSTR - i < 4) ? N_INSTR - i : 4;
                    pick = i + 1 + int'(next_rand() % 32'(span));
                    tgt  = RESET_VEC + 16'(at[pick]);
                    prog[at[i] + 1] = tgt[15:8];
                    prog[at[i] + 2] = tgt[7:0];
                end
                default: prog[at[i] + 1] = 8'(next_rand());
            endcase
        end
        // terminal loop
        prog[pos]     = JMP;
        prog[pos + 1] = end_addr[15:8];
        prog[pos + 2] = end_addr[7:0];
        prog_len      = pos + 3;
    endtask

    // reference model, expected writes in program order
    task automatic build_expected();
        int          pc;
        logic [7:0]  op;
        logic [7:0]  opnd;
        logic [7:0]  a;
        logic [7:0]  b;
        logic        c;
        logic [15:0] ea;
        pc = 0;
        a  = 8'h00;
        b  = 8'h00;
        c  = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        while (RESET_VEC + 16'(pc) != end_addr) begin
            op   = prog[pc];
            opnd = prog[pc + 1];
            ea   = {prog[pc + 1], prog[pc + 2]};
            pc   = pc + op_len(op);
            case (op)
                LDA:  a = opnd;
                LDB:  b = opnd;
                ADDA: {c, a} = {1'b0, a} + {1'b0, opnd};
                ADCA: {c, a} = {1'b0, a} + {1'b0, opnd} + {8'h00, c};
                // C is the borrow
                SUBA: {c, a} = {1'b0, a} - {1'b0, opnd};
                ANDA: a = a & opnd;
                EORA: a = a ^ opnd;
                ABA:  {c, a} = {1'b0, a} + {1'b0, b};
                STA: begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(a);
                end
                STB: begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                JMP:     pc = int'(ea - RESET_VEC);
                default: ;
            endcase
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h5A);
        end
        for (int k = 0; k < prog_len; k++) begin
            mem[RESET_VEC + 16'(k)] = prog[k];
        end
    endtask

    task automatic run_test(input string name, input bit gate_cen, input bit use_halt);
        int                wr_idx;
        int                halt_left;
        int                halt_run;
        int                tail;
        int                loop_hits;
        bit                seen_end;
        logic [ADDR_W-1:0] last_addr;
        wr_idx    = 0;
        halt_left = 0;
        halt_run  = 0;
        tail      = 0;
        loop_hits = 0;
        seen_end  = 1'b0;
        last_addr = RESET_VEC;
        load_memory();
        cycles = 0;
        rst_n  = 1'b0;
        cen    = 1'b1;
        halt   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (addr !== RESET_VEC) begin
            $display("Error %s: first address expected %h actual %h", name, RESET_VEC, addr);
            val_errors++;
        end
        if (we !== 1'b0) begin
            $display("Error %s: we after reset expected 0 actual %b", name, we);
            val_errors++;
        end
        while (tail < 24) begin
            cen = gate_cen ? ((next_rand() & 32'd1) != 0) : 1'b1;
            if (use_halt && !seen_end) begin
                if (halt_left == 0 && (next_rand() & 63) == 0) begin
                    halt_left = 6 + int'(next_rand() % 8);
                end
                halt = (halt_left != 0);
                if (cen && halt_left != 0) begin
                    halt_left--;
                end
            end else begin
                halt      = 1'b0;
                halt_left = 0;
            end
            if (cen) begin
                halt_run = halt ? halt_run + 1 : 0;
                // by the fifth halted cycle the core sits in HALTED
                if (halt_run >= 5 && (we || addr !== last_addr)) begin
                    $display("bus moved while halted in %s, addr %h we %b", name, addr, we);
                    other_errors++;
                end
                if (we) begin
                    writes_seen++;
                    if (wr_idx >= exp_addr.size()) begin
                        $display("unexpected extra write in %s to %h", name, addr);
                        other_errors++;
                    end else begin
                        if (addr !== exp_addr[wr_idx] || dout !== exp_data[wr_idx]) begin
                            $display("Error %s: write %0d expected %h=%h actual %h=%h", name,
                                     wr_idx, exp_addr[wr_idx], exp_data[wr_idx], addr, dout);
                            val_errors++;
                        end
                        wr_idx++;
                    end
                    mem[addr] = dout;
                end
                if (addr == end_addr) begin
                    seen_end = 1'b1;
                end
                if (seen_end) begin
                    tail++;
                    loop_hits = (addr == end_addr) ? loop_hits + 1 : loop_hits;
                    if (addr < end_addr || addr > end_addr + 2) begin
                        $display("left the terminal loop in %s, addr %h", name, addr);
                        other_errors++;
                    end
                end
                last_addr = addr;
            end
            @(negedge clk);
        end
        if (wr_idx != exp_addr.size() || loop_hits < 6) begin
            $display("%s ended with %0d of %0d writes and %0d loop fetches", name, wr_idx,
                     exp_addr.size(), loop_hits);
            other_errors++;
        end
    endtask

    initial begin
        rng_state    = 32'd29;
        rst_n        = 1'b0;
        cen          = 1'b0;
        halt         = 1'b0;
        cycles       = 0;
        val_errors   = 0;
        other_errors = 0;
        writes_seen  = 0;
        gen_program();
        build_expected();
        $display("program of %0d bytes, %0d stores expected", prog_len, exp_addr.size());
        run_test("cen_high", 1'b0, 1'b0);
        run_test("cen_gated", 1'b1, 1'b0);
        run_test("halt_pulses", 1'b1, 1'b1);
        $display("writes seen %0d, value errors %0d, other errors %0d", writes_seen,
                 val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
